// File: cache_cfg.svh
`ifndef CACHE_CFG_SVH
`define CACHE_CFG_SVH

`define BYTE_LEN_IN_BITS        8       // One write-mask lane
`define CACHE_NUM_SET           16
`define CACHE_NUM_WAY           4
`define CACHE_SET_BITS          4       // Low address bits
`define CACHE_TAG_BITS          8       // High address bits
`define CACHE_ADDR_BITS         12

`define CACHE_DATA_BITS         32

// Tag entry layout is {valid, zero pad, tag}
`define CACHE_TAG_ENTRY_BITS    16

`define CACHE_COUNT_BITS        16      // Hit and miss counters

`endif

// File: cache_pkg.sv
`default_nettype none

package cache_pkg;

typedef enum logic [1:0]
{
    OP_READ  = 2'd0,
    OP_WRITE = 2'd1,
    OP_FILL  = 2'd2     // Installs a line in the victim way
} cache_op_t;

typedef enum logic [1:0]
{
    ST_IDLE    = 2'd0,
    ST_COMPARE = 2'd1,
    ST_RESPOND = 2'd2
} lookup_state_t;

endpackage

`default_nettype wire

// File: single_port_lutram.sv
`default_nettype none

`include "cache_cfg.svh"

module single_port_lutram
#(
    parameter int SINGLE_ENTRY_SIZE_IN_BITS = 32,
    parameter int NUM_SET                   = 16,
    parameter int SET_PTR_WIDTH_IN_BITS     = $clog2(NUM_SET),
    parameter int WRITE_MASK_LEN            = SINGLE_ENTRY_SIZE_IN_BITS / `BYTE_LEN_IN_BITS
)
(
    input  logic                                    clk_in,
    input  logic                                    reset_in,
    input  logic                                    access_en_in,
    input  logic [WRITE_MASK_LEN - 1 : 0]           write_en_in,
    input  logic [SET_PTR_WIDTH_IN_BITS - 1 : 0]    access_set_addr_in,
    input  logic [SINGLE_ENTRY_SIZE_IN_BITS - 1 : 0] write_entry_in,
    output logic [SINGLE_ENTRY_SIZE_IN_BITS - 1 : 0] read_entry_out
);

logic [SINGLE_ENTRY_SIZE_IN_BITS - 1 : 0] mem [NUM_SET];

always_ff @(posedge clk_in or posedge reset_in)
begin
    if (reset_in)
    begin
        for (int s = 0; s < NUM_SET; s++)
        begin
            mem[s] <= '0;
        end
        read_entry_out <= '0;
    end
    else if (access_en_in)
    begin
        for (int b = 0; b < WRITE_MASK_LEN; b++)
        begin
            if (write_en_in[b])
            begin
                mem[access_set_addr_in][b * `BYTE_LEN_IN_BITS +: `BYTE_LEN_IN_BITS] <=
                    write_entry_in[b * `BYTE_LEN_IN_BITS +: `BYTE_LEN_IN_BITS];
            end
        end
        read_entry_out <= mem[access_set_addr_in];     // Old contents on a write
    end
end

endmodule

`default_nettype wire

// File: associative_single_port_array.sv
`default_nettype none

`include "cache_cfg.svh"

module associative_single_port_array
#(
    parameter int SINGLE_ENTRY_SIZE_IN_BITS = 32,
    parameter int NUM_SET                   = 16,
    parameter int NUM_WAY                   = 4,
    parameter int SET_PTR_WIDTH_IN_BITS     = $clog2(NUM_SET),
    parameter int WRITE_MASK_LEN            = SINGLE_ENTRY_SIZE_IN_BITS / `BYTE_LEN_IN_BITS
)
(
    input  logic                                            clk_in,
    input  logic                                            reset_in,

    input  logic                                            access_en_in,
    input  logic [WRITE_MASK_LEN - 1 : 0]                   write_en_in,

    input  logic [SET_PTR_WIDTH_IN_BITS - 1 : 0]            access_set_addr_in,
    input  logic [NUM_WAY - 1 : 0]                          way_select_in,

    input  logic [SINGLE_ENTRY_SIZE_IN_BITS - 1 : 0]        write_single_entry_in,
    output logic [SINGLE_ENTRY_SIZE_IN_BITS * NUM_WAY - 1 : 0] read_set_out,
    output logic [SINGLE_ENTRY_SIZE_IN_BITS - 1 : 0]        read_single_entry_out
);

logic [SINGLE_ENTRY_SIZE_IN_BITS * NUM_WAY - 1 : 0] data_to_mux;
logic [NUM_WAY - 1 : 0]                             way_select_stage;

assign read_set_out = data_to_mux;

generate
    for (genvar gen = 0; gen < NUM_WAY; gen++)
    begin : g_way
        single_port_lutram
        #(
            .SINGLE_ENTRY_SIZE_IN_BITS  (SINGLE_ENTRY_SIZE_IN_BITS),
            .NUM_SET                    (NUM_SET),
            .SET_PTR_WIDTH_IN_BITS      (SET_PTR_WIDTH_IN_BITS),
            .WRITE_MASK_LEN             (WRITE_MASK_LEN)
        )
        entry_way
        (
            .clk_in                     (clk_in),
            .reset_in                   (reset_in),
            .access_en_in               (access_en_in & way_select_in[gen]),
            .write_en_in                (write_en_in & {WRITE_MASK_LEN{way_select_in[gen]}}),
            .access_set_addr_in         (access_set_addr_in),
            .write_entry_in             (write_single_entry_in),
            .read_entry_out             (data_to_mux[gen * SINGLE_ENTRY_SIZE_IN_BITS +:
                                                     SINGLE_ENTRY_SIZE_IN_BITS])
        );
    end
endgenerate

// Lines the select up with the registered read
always_ff @(posedge clk_in or posedge reset_in)
begin
    if (reset_in)
    begin
        way_select_stage <= '0;
    end
    else
    begin
        way_select_stage <= way_select_in;
    end
end

always_comb
begin
    read_single_entry_out = '0;
    for (int w = 0; w < NUM_WAY; w++)
    begin
        read_single_entry_out = read_single_entry_out |
            (data_to_mux[w * SINGLE_ENTRY_SIZE_IN_BITS +: SINGLE_ENTRY_SIZE_IN_BITS] &
             {SINGLE_ENTRY_SIZE_IN_BITS{way_select_stage[w]}});   // Zero when none selected
    end
end

endmodule

`default_nettype wire

// File: cache_lookup_ctrl.sv
`default_nettype none

`include "cache_cfg.svh"

module cache_lookup_ctrl
    import cache_pkg::*;
(
    input  logic                                                    clk_in,
    input  logic                                                    reset_in,

    input  logic                                                    req_valid,
    input  cache_op_t                                               req_op,
    input  logic [`CACHE_ADDR_BITS - 1 : 0]                         req_addr,
    input  logic [`CACHE_DATA_BITS - 1 : 0]                         req_wdata,
    input  logic [(`CACHE_DATA_BITS / `BYTE_LEN_IN_BITS) - 1 : 0]   req_byte_en,
    output logic                                                    busy,

    output logic                                                    tag_access_en,
    output logic [(`CACHE_TAG_ENTRY_BITS / `BYTE_LEN_IN_BITS) - 1 : 0] tag_write_en,
    output logic [`CACHE_SET_BITS - 1 : 0]                          tag_set_addr,
    output logic [`CACHE_NUM_WAY - 1 : 0]                           tag_way_select,
    output logic [`CACHE_TAG_ENTRY_BITS - 1 : 0]                    tag_write_entry,
    input  logic [`CACHE_TAG_ENTRY_BITS * `CACHE_NUM_WAY - 1 : 0]   tag_read_set,

    output logic                                                    data_access_en,
    output logic [(`CACHE_DATA_BITS / `BYTE_LEN_IN_BITS) - 1 : 0]   data_write_en,
    output logic [`CACHE_SET_BITS - 1 : 0]                          data_set_addr,
    output logic [`CACHE_NUM_WAY - 1 : 0]                           data_way_select,
    output logic [`CACHE_DATA_BITS - 1 : 0]                         data_write_entry,

    output logic                                                    issue_valid,
    output cache_op_t                                               issue_op,
    output logic                                                    issue_hit
);

localparam int ENTRY_BITS = `CACHE_TAG_ENTRY_BITS;
localparam int PTR_BITS   = $clog2(`CACHE_NUM_WAY);

lookup_state_t                          state;
cache_op_t                              cap_op;
logic [`CACHE_SET_BITS - 1 : 0]         cap_set;
logic [`CACHE_TAG_BITS - 1 : 0]         cap_tag;
logic [`CACHE_DATA_BITS - 1 : 0]        cap_wdata;
logic [(`CACHE_DATA_BITS / `BYTE_LEN_IN_BITS) - 1 : 0] cap_byte_en;
logic [PTR_BITS - 1 : 0]                victim_ptr [`CACHE_NUM_SET];
logic [`CACHE_NUM_WAY - 1 : 0]          hit_way;
logic [`CACHE_NUM_WAY - 1 : 0]          victim_way;
logic                                   accept;

assign accept = req_valid && (state == ST_IDLE);
assign busy   = (state != ST_IDLE);

assign issue_valid = (state == ST_COMPARE);
assign issue_op    = cap_op;
assign issue_hit   = |hit_way;

always_comb
begin
    for (int w = 0; w < `CACHE_NUM_WAY; w++)
    begin
        hit_way[w] = tag_read_set[w * ENTRY_BITS + ENTRY_BITS - 1] &&
                     (tag_read_set[w * ENTRY_BITS +: `CACHE_TAG_BITS] == cap_tag);
        victim_way[w] = (victim_ptr[cap_set] == PTR_BITS'(w));
    end
end

always_comb
begin
    tag_access_en    = 1'b0;
    tag_write_en     = '0;
    tag_set_addr     = req_addr[`CACHE_SET_BITS - 1 : 0];
    tag_way_select   = '0;
    tag_write_entry  = {1'b1, {(ENTRY_BITS - `CACHE_TAG_BITS - 1){1'b0}}, cap_tag};
    data_access_en   = 1'b0;
    data_write_en    = '0;
    data_set_addr    = cap_set;
    data_way_select  = '0;
    data_write_entry = cap_wdata;

    case (state)
        ST_IDLE:
        begin
            if (accept)
            begin
                tag_access_en  = 1'b1;     // Read the whole set
                tag_way_select = '1;
            end
        end
        ST_COMPARE:
        begin
            tag_set_addr = cap_set;
            case (cap_op)
                OP_FILL:
                begin
                    tag_access_en   = 1'b1;
                    tag_write_en    = '1;
                    tag_way_select  = victim_way;
                    data_access_en  = 1'b1;
                    data_write_en   = '1;
                    data_way_select = victim_way;
                end
                OP_WRITE:
                begin
                    data_access_en  = |hit_way;
                    data_write_en   = cap_byte_en;
                    data_way_select = hit_way;
                end
                default:
                begin
                    data_access_en  = |hit_way;    // Miss leaves select at zero
                    data_way_select = hit_way;
                end
            endcase
        end
        default:
        begin
        end
    endcase
end

always_ff @(posedge clk_in or posedge reset_in)
begin
    if (reset_in)
    begin
        state <= ST_IDLE;
        for (int s = 0; s < `CACHE_NUM_SET; s++)
        begin
            victim_ptr[s] <= '0;
        end
    end
    else
    begin
        case (state)
            ST_IDLE:
            begin
                if (accept)
                begin
                    state <= ST_COMPARE;
                end
            end
            ST_COMPARE:
            begin
                state <= ST_RESPOND;
                if (cap_op == OP_FILL)
                begin
                    victim_ptr[cap_set] <= victim_ptr[cap_set] + 1'b1;
                end
            end
            default:
            begin
                state <= ST_IDLE;
            end
        endcase
    end
end

always_ff @(posedge clk_in)
begin
    if (accept)
    begin
        cap_op      <= req_op;
        cap_set     <= req_addr[`CACHE_SET_BITS - 1 : 0];
        cap_tag     <= req_addr[`CACHE_ADDR_BITS - 1 -: `CACHE_TAG_BITS];
        cap_wdata   <= req_wdata;
        cap_byte_en <= req_byte_en;
    end
end

endmodule

`default_nettype wire

// File: cache_response_unit.sv
`default_nettype none

`include "cache_cfg.svh"

module cache_response_unit
    import cache_pkg::*;
(
    input  logic                                clk_in,
    input  logic                                reset_in,

    input  logic                                issue_valid,
    input  cache_op_t                           issue_op,
    input  logic                                issue_hit,
    input  logic [`CACHE_DATA_BITS - 1 : 0]     read_data,

    output logic                                rsp_valid,
    output cache_op_t                           rsp_op,
    output logic                                rsp_hit,
    output logic [`CACHE_DATA_BITS - 1 : 0]     rsp_data,
    output logic [`CACHE_COUNT_BITS - 1 : 0]    hit_count,
    output logic [`CACHE_COUNT_BITS - 1 : 0]    miss_count
);

logic       stage_valid;
cache_op_t  stage_op;
logic       stage_hit;

always_ff @(posedge clk_in or posedge reset_in)
begin
    if (reset_in)
    begin
        stage_valid <= 1'b0;
        rsp_valid   <= 1'b0;
        hit_count   <= '0;
        miss_count  <= '0;
    end
    else
    begin
        stage_valid <= issue_valid;
        rsp_valid   <= stage_valid;
        // Fills are not lookups
        if (stage_valid && (stage_op != OP_FILL))
        begin
            if (stage_hit)
            begin
                hit_count <= hit_count + 1'b1;
            end
            else
            begin
                miss_count <= miss_count + 1'b1;
            end
        end
    end
end

always_ff @(posedge clk_in)
begin
    if (issue_valid)
    begin
        stage_op  <= issue_op;
        stage_hit <= issue_hit;
    end
    if (stage_valid)
    begin
        rsp_op   <= stage_op;
        rsp_hit  <= stage_hit;
        rsp_data <= read_data;     // Array output is valid this cycle
    end
end

endmodule

`default_nettype wire

// File: cache_subsystem.sv
`default_nettype none

`include "cache_cfg.svh"

module cache_subsystem
    import cache_pkg::*;
(
    input  logic                                                    clk_in,
    input  logic                                                    reset_in,

    input  logic                                                    req_valid,
    input  cache_op_t                                               req_op,
    input  logic [`CACHE_ADDR_BITS - 1 : 0]                         req_addr,
    input  logic [`CACHE_DATA_BITS - 1 : 0]                         req_wdata,
    input  logic [(`CACHE_DATA_BITS / `BYTE_LEN_IN_BITS) - 1 : 0]   req_byte_en,
    output logic                                                    busy,

    output logic                                                    rsp_valid,
    output cache_op_t                                               rsp_op,
    output logic                                                    rsp_hit,
    output logic [`CACHE_DATA_BITS - 1 : 0]                         rsp_data,
    output logic [`CACHE_COUNT_BITS - 1 : 0]                        hit_count,
    output logic [`CACHE_COUNT_BITS - 1 : 0]                        miss_count
);

logic                                                   tag_access_en;
logic [(`CACHE_TAG_ENTRY_BITS / `BYTE_LEN_IN_BITS) - 1 : 0] tag_write_en;
logic [`CACHE_SET_BITS - 1 : 0]                         tag_set_addr;
logic [`CACHE_NUM_WAY - 1 : 0]                          tag_way_select;
logic [`CACHE_TAG_ENTRY_BITS - 1 : 0]                   tag_write_entry;
logic [`CACHE_TAG_ENTRY_BITS * `CACHE_NUM_WAY - 1 : 0]  tag_read_set;

logic                                                   data_access_en;
logic [(`CACHE_DATA_BITS / `BYTE_LEN_IN_BITS) - 1 : 0]  data_write_en;
logic [`CACHE_SET_BITS - 1 : 0]                         data_set_addr;
logic [`CACHE_NUM_WAY - 1 : 0]                          data_way_select;
logic [`CACHE_DATA_BITS - 1 : 0]                        data_write_entry;
logic [`CACHE_DATA_BITS - 1 : 0]                        data_read_entry;

logic                                                   issue_valid;
cache_op_t                                              issue_op;
logic                                                   issue_hit;

cache_lookup_ctrl ctrl0
(
    .clk_in             (clk_in),
    .reset_in           (reset_in),
    .req_valid          (req_valid),
    .req_op             (req_op),
    .req_addr           (req_addr),
    .req_wdata          (req_wdata),
    .req_byte_en        (req_byte_en),
    .busy               (busy),
    .tag_access_en      (tag_access_en),
    .tag_write_en       (tag_write_en),
    .tag_set_addr       (tag_set_addr),
    .tag_way_select     (tag_way_select),
    .tag_write_entry    (tag_write_entry),
    .tag_read_set       (tag_read_set),
    .data_access_en     (data_access_en),
    .data_write_en      (data_write_en),
    .data_set_addr      (data_set_addr),
    .data_way_select    (data_way_select),
    .data_write_entry   (data_write_entry),
    .issue_valid        (issue_valid),
    .issue_op           (issue_op),
    .issue_hit          (issue_hit)
);

// Only the whole set is read from the tag side
associative_single_port_array
#(
    .SINGLE_ENTRY_SIZE_IN_BITS  (`CACHE_TAG_ENTRY_BITS),
    .NUM_SET                    (`CACHE_NUM_SET),
    .NUM_WAY                    (`CACHE_NUM_WAY)
)
tag_array
(
    .clk_in                 (clk_in),
    .reset_in               (reset_in),
    .access_en_in           (tag_access_en),
    .write_en_in            (tag_write_en),
    .access_set_addr_in     (tag_set_addr),
    .way_select_in          (tag_way_select),
    .write_single_entry_in  (tag_write_entry),
    .read_set_out           (tag_read_set),
    .read_single_entry_out  ()
);

associative_single_port_array
#(
    .SINGLE_ENTRY_SIZE_IN_BITS  (`CACHE_DATA_BITS),
    .NUM_SET                    (`CACHE_NUM_SET),
    .NUM_WAY                    (`CACHE_NUM_WAY)
)
data_array
(
    .clk_in                 (clk_in),
    .reset_in               (reset_in),
    .access_en_in           (data_access_en),
    .write_en_in            (data_write_en),
    .access_set_addr_in     (data_set_addr),
    .way_select_in          (data_way_select),
    .write_single_entry_in  (data_write_entry),
    .read_set_out           (),
    .read_single_entry_out  (data_read_entry)
);

cache_response_unit rsp0
(
    .clk_in         (clk_in),
    .reset_in       (reset_in),
    .issue_valid    (issue_valid),
    .issue_op       (issue_op),
    .issue_hit      (issue_hit),
    .read_data      (data_read_entry),
    .rsp_valid      (rsp_valid),
    .rsp_op         (rsp_op),
    .rsp_hit        (rsp_hit),
    .rsp_data       (rsp_data),
    .hit_count      (hit_count),
    .miss_count     (miss_count)
);

endmodule

`default_nettype wire

// File: cache_tb_assert.sv
`default_nettype none

module cache_tb_assert
(
    input logic clk_in,
    input logic reset_in,
    input logic req_valid,
    input logic busy,
    input logic rsp_valid
);

logic accept;

assign accept = req_valid && !busy;

rsp_pulse_a : assert property (@(posedge clk_in) disable iff (reset_in)
    $past(rsp_valid) |-> !rsp_valid)
    else $error("rsp_valid stayed high for more than one cycle");

// Registered at acceptance plus 2, seen by the sampling one edge later
rsp_after_accept_a : assert property (@(posedge clk_in) disable iff (reset_in)
    $past(accept, 3) |-> rsp_valid)
    else $error("rsp_valid missing two cycles after acceptance");

rsp_needs_accept_a : assert property (@(posedge clk_in) disable iff (reset_in)
    rsp_valid |-> $past(accept, 3))
    else $error("rsp_valid without a request two cycles before");

busy_after_reset_a : assert property (@(posedge clk_in)
    $fell(reset_in) |-> !busy)
    else $error("busy high after reset");

endmodule

bind cache_subsystem cache_tb_assert assert0
(
    .clk_in     (clk_in),
    .reset_in   (reset_in),
    .req_valid  (req_valid),
    .busy       (busy),
    .rsp_valid  (rsp_valid)
);

`default_nettype wire

// File: cache_tb.sv
`default_nettype none

`include "cache_cfg.svh"

module cache_tb
    import cache_pkg::*;
();

localparam int WAIT_LIMIT = 20;
localparam int NUM_BYTES  = `CACHE_DATA_BITS / `BYTE_LEN_IN_BITS;

logic                               clk_in;
logic                               reset_in;
logic                               req_valid;
cache_op_t                          req_op;
logic [`CACHE_ADDR_BITS - 1 : 0]    req_addr;
logic [`CACHE_DATA_BITS - 1 : 0]    req_wdata;
logic [NUM_BYTES - 1 : 0]           req_byte_en;
logic                               busy;
logic                               rsp_valid;
cache_op_t                          rsp_op;
logic                               rsp_hit;
logic [`CACHE_DATA_BITS - 1 : 0]    rsp_data;
logic [`CACHE_COUNT_BITS - 1 : 0]   hit_count;
logic [`CACHE_COUNT_BITS - 1 : 0]   miss_count;

// Reference model of the cache contents
logic [`CACHE_TAG_BITS - 1 : 0]     model_tag    [`CACHE_NUM_SET][`CACHE_NUM_WAY];
logic                               model_valid  [`CACHE_NUM_SET][`CACHE_NUM_WAY];
logic [`CACHE_DATA_BITS - 1 : 0]    model_data   [`CACHE_NUM_SET][`CACHE_NUM_WAY];
logic [1:0]                         model_victim [`CACHE_NUM_SET];
int                                 exp_hits;
int                                 exp_misses;
int                                 error_count;
int                                 timeout_count;
logic [31:0]                        rand_state;

cache_subsystem dut0
(
    .clk_in         (clk_in),
    .reset_in       (reset_in),
    .req_valid      (req_valid),
    .req_op         (req_op),
    .req_addr       (req_addr),
    .req_wdata      (req_wdata),
    .req_byte_en    (req_byte_en),
    .busy           (busy),
    .rsp_valid      (rsp_valid),
    .rsp_op         (rsp_op),
    .rsp_hit        (rsp_hit),
    .rsp_data       (rsp_data),
    .hit_count      (hit_count),
    .miss_count     (miss_count)
);

initial
begin
    clk_in = 1'b0;
    forever #5 clk_in = ~clk_in;
end

function automatic logic [31:0] next_random();
    rand_state = rand_state * 32'd1664525 + 32'd1013904223;
    return rand_state;
endfunction

function automatic int find_way(input logic [3:0] set, input logic [7:0] tag);
    int way;
    way = -1;
    for (int w = 0; w < `CACHE_NUM_WAY; w++)
    begin
        if (model_valid[set][w] && (model_tag[set][w] == tag))
        begin
            way = w;
        end
    end
    return way;
endfunction

function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                            input logic [31:0] new_word,
                                            input logic [3:0] mask);
    logic [31:0] merged;
    merged = old_word;
    for (int b = 0; b < NUM_BYTES; b++)
    begin
        if (mask[b])
        begin
            merged[b * 8 +: 8] = new_word[b * 8 +: 8];
        end
    end
    return merged;
endfunction

task automatic check_equal(input logic [31:0] actual, input logic [31:0] expected,
                           input string what);
    assert (actual === expected)
    else
    begin
        $display("error %0t: %s is %h, expected %h", $time, what, actual, expected);
        error_count++;
    end
endtask

task automatic end_run();
    $display("Run complete: %0d errors, %0d timeouts", error_count, timeout_count);
    if ((error_count == 0) && (timeout_count == 0))
    begin
        $display("*** TEST PASSED ***");
    end
    else
    begin
        $display("*** TEST FAILED ***");
    end
    $finish;
endtask

// Issues one request, updates the model and checks the response
task automatic do_request(input cache_op_t op, input logic [11:0] addr,
                          input logic [31:0] wdata, input logic [3:0] byte_en);
    logic [3:0]  set;
    logic [7:0]  tag;
    int          way;
    int          cycles;
    logic        exp_hit;
    logic        check_data;
    logic [31:0] exp_data;
    set = addr[3:0];
    tag = addr[11:4];
    way = find_way(set, tag);
    exp_hit = (way >= 0);
    exp_data = '0;
    check_data = (op == OP_READ) || ((op == OP_WRITE) && !exp_hit);
    if ((op == OP_READ) && exp_hit)
    begin
        exp_data = model_data[set][way];
    end
    if ((op == OP_WRITE) && exp_hit)
    begin
        model_data[set][way] = merge_bytes(model_data[set][way], wdata, byte_en);
    end
    if (op == OP_FILL)
    begin
        model_tag[set][model_victim[set]] = tag;
        model_valid[set][model_victim[set]] = 1'b1;
        model_data[set][model_victim[set]] = wdata;
        model_victim[set] = model_victim[set] + 2'd1;
    end
    else if (exp_hit)
    begin
        exp_hits++;
    end
    else
    begin
        exp_misses++;
    end

    cycles = 0;
    while (busy && (cycles < WAIT_LIMIT))
    begin
        @(negedge clk_in);
        cycles++;
    end
    if (busy)
    begin
        $display("Timeout at %0t: busy never went low before a new request", $time);
        timeout_count++;
    end
    else
    begin
        req_valid   = 1'b1;
        req_op      = op;
        req_addr    = addr;
        req_wdata   = wdata;
        req_byte_en = byte_en;
        @(posedge clk_in);                  // Acceptance edge
        @(negedge clk_in);
        req_valid = 1'b0;
        check_equal(32'(busy), 32'd1, "busy after acceptance");
        cycles = 0;
        while (!rsp_valid && (cycles < WAIT_LIMIT))
        begin
            @(negedge clk_in);
            cycles++;
        end
        if (!rsp_valid)
        begin
            $display("Timeout at %0t: no response arrived for a request", $time);
            timeout_count++;
        end
        else
        begin
            check_equal(cycles, 32'd2, "response latency");
            check_equal(32'(busy), 32'd0, "busy during response");
            check_equal(32'(rsp_op), 32'(op), "rsp_op");
            check_equal(32'(rsp_hit), 32'(exp_hit), "rsp_hit");
            if (check_data)
            begin
                check_equal(rsp_data, exp_data, "rsp_data");
            end
            check_equal(32'(hit_count), 32'(exp_hits), "hit_count");
            check_equal(32'(miss_count), 32'(exp_misses), "miss_count");
        end
    end
endtask

task automatic test_after_reset();
    logic [31:0] pick;
    check_equal(32'(busy), 32'd0, "busy after reset");
    check_equal(32'(rsp_valid), 32'd0, "rsp_valid after reset");
    check_equal(32'(hit_count), 32'd0, "hit_count after reset");
    check_equal(32'(miss_count), 32'd0, "miss_count after reset");
    for (int i = 0; i < 4; i++)
    begin
        pick = next_random();
        do_request(OP_READ, pick[31:20], '0, '0);
    end
endtask

task automatic test_fill_then_read();
    do_request(OP_FILL, 12'h125, next_random(), 4'hF);
    do_request(OP_READ, 12'h125, '0, '0);
    do_request(OP_FILL, 12'h9D0, next_random(), 4'hF);
    do_request(OP_READ, 12'h9D0, '0, '0);
endtask

task automatic test_masked_write();
    logic [31:0] pick;
    do_request(OP_FILL, 12'h3A7, next_random(), 4'hF);
    for (int i = 0; i < 3; i++)
    begin
        pick = next_random();
        do_request(OP_WRITE, 12'h3A7, next_random(), pick[27:24]);
        do_request(OP_READ, 12'h3A7, '0, '0);
    end
    do_request(OP_WRITE, 12'h5B7, next_random(), 4'hF);     // Tag not present
    do_request(OP_READ, 12'h3A7, '0, '0);
    do_request(OP_READ, 12'h5B7, '0, '0);
endtask

task automatic test_round_robin();
    for (int i = 0; i < 5; i++)
    begin
        do_request(OP_FILL, {8'(8'h10 + i), 4'hC}, next_random(), 4'hF);
    end
    // First tag was replaced by the fifth fill
    for (int i = 0; i < 5; i++)
    begin
        do_request(OP_READ, {8'(8'h10 + i), 4'hC}, '0, '0);
    end
endtask

task automatic test_mixed_traffic();
    logic [31:0] pick;
    logic [11:0] addr;
    cache_op_t   op;
    for (int i = 0; i < 80; i++)
    begin
        pick = next_random();
        addr = {5'b1000_0, pick[31:29], 2'b00, pick[27:26]};
        case (pick[24:23])
            2'd1:    op = OP_WRITE;
            2'd2:    op = OP_FILL;
            default: op = OP_READ;
        endcase
        if ((op == OP_FILL) && (find_way(addr[3:0], addr[11:4]) >= 0))
        begin
            op = OP_READ;                   // Fills install absent tags only
        end
        do_request(op, addr, next_random(), pick[21:18]);
    end
    check_equal(32'(hit_count), 32'(exp_hits), "final hit_count");
    check_equal(32'(miss_count), 32'(exp_misses), "final miss_count");
endtask

task automatic test_response_timing();
    do_request(OP_READ, 12'h77E, '0, '0);
    do_request(OP_FILL, 12'h77E, next_random(), 4'hF);
    do_request(OP_WRITE, 12'h77E, next_random(), 4'h5);
    do_request(OP_READ, 12'h77E, '0, '0);
    do_request(OP_WRITE, 12'h78E, next_random(), 4'hA);
endtask

initial
begin
    rand_state    = 32'h48e4_bc04;
    error_count   = 0;
    timeout_count = 0;
    exp_hits      = 0;
    exp_misses    = 0;
    reset_in      = 1'b1;
    req_valid     = 1'b0;
    req_op        = OP_READ;
    req_addr      = '0;
    req_wdata     = '0;
    req_byte_en   = '0;
    for (int s = 0; s < `CACHE_NUM_SET; s++)
    begin
        model_victim[s] = '0;
        for (int w = 0; w < `CACHE_NUM_WAY; w++)
        begin
            model_tag[s][w]   = '0;
            model_valid[s][w] = 1'b0;
            model_data[s][w]  = '0;
        end
    end
    repeat (5) @(posedge clk_in);
    @(negedge clk_in);
    reset_in = 1'b0;

    test_after_reset();
    test_fill_then_read();
    test_masked_write();
    test_round_robin();
    test_mixed_traffic();
    test_response_timing();
    end_run();
end

endmodule

`default_nettype wire

// File: all.f
+incdir+.
cache_pkg.sv
single_port_lutram.sv
associative_single_port_array.sv
cache_lookup_ctrl.sv
cache_response_unit.sv
cache_subsystem.sv
cache_tb_assert.sv
cache_tb.sv

// File: run_sim.sh
#!/bin/sh
# Compiles and runs the cache testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f all.f --top-module cache_tb -o cache_tb_sim
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

./obj_dir/cache_tb_sim > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -F -q "*** TEST FAILED ***" sim.log; then
    exit 1
fi

exit 0
